/* filelist.f */
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/decode_ctl.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/decode_stage.sv
tb/tb_decode_stage.sv

/* Bender.yml */
package:
  name: rv_decode_stage

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_ctrl_pkg.sv
  - hdl/decode_ctl.sv
  - hdl/imm_gen.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - tb/tb_decode_stage.sv

/* tb/tb_decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_decode_stage;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Run length bounds in cycles
    localparam int MIN_CYCLES = 200;
    localparam int RUN_LIMIT  = 2000;

    // Cover slots after the six format codes
    localparam int COV_JALR    = 6;
    localparam int COV_WT      = 7;
    localparam int COV_X0      = 8;
    localparam int COV_STALL   = 9;
    localparam int COV_ILL_V   = 10;
    localparam int COV_ILL_INV = 11;
    localparam int COV_N       = 12;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    word_t     instruction = 32'h0000_0013;
    logic      instr_valid = 1'b0;
    logic      stall = 1'b0;
    logic      wb_en = 1'b0;
    reg_addr_t wb_addr = '0;
    word_t     wb_data = '0;

    word_t     instr_exe;
    logic      valid_exe;
    logic      illegal_exe;
    imm_sel_t  imm_sel_exe;
    word_t     imm_exe;
    word_t     rs1_data_exe;
    word_t     rs2_data_exe;

    // Shadow register array and expected ID/EX contents
    word_t     shadow [NUM_REGS];
    word_t     exp_instr;
    logic      exp_valid;
    logic      exp_illegal;
    imm_sel_t  exp_imm_sel;
    word_t     exp_imm;
    word_t     exp_rs1;
    word_t     exp_rs2;

    integer    seed = 32'h4e5;
    int        cycles;
    int        cover_cnt [COV_N];
    logic      x0_written = 1'b0;

    // Opcode pools for stimulus
    opcode_t legal_opc [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                                OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYSTEM};
    opcode_t bad_opc [4] = '{7'h7f, 7'h00, 7'h5b, 7'h0b};

    decode_stage i_dut (
        .clk          (clk),
        .rst          (rst),
        .instruction  (instruction),
        .instr_valid  (instr_valid),
        .stall        (stall),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .instr_exe    (instr_exe),
        .valid_exe    (valid_exe),
        .illegal_exe  (illegal_exe),
        .imm_sel_exe  (imm_sel_exe),
        .imm_exe      (imm_exe),
        .rs1_data_exe (rs1_data_exe),
        .rs2_data_exe (rs2_data_exe)
    );

    always #10 clk = ~clk;

    // Format table straight from the RV32I encoding list
    function automatic imm_sel_t expected_format(input opcode_t opc);
        case (opc)
            OPC_LUI, OPC_AUIPC:              return IMM_U;
            OPC_JAL:                         return IMM_J;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:  return IMM_I;
            OPC_BRANCH:                      return IMM_B;
            OPC_STORE:                       return IMM_S;
            default:                         return IMM_NONE;
        endcase
    endfunction

    function automatic logic opcode_known(input opcode_t opc);
        foreach (legal_opc[k]) begin
            if (legal_opc[k] == opc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Immediate fields packed at the top and shifted down arithmetically
    function automatic word_t expected_immediate(input word_t w, input imm_sel_t fmt);
        logic signed [31:0] s;
        case (fmt)
            IMM_I:   s = $signed(w) >>> 20;
            IMM_S:   s = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
            IMM_B:   s = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19;
            IMM_U:   s = {w[31:12], 12'b0};
            IMM_J:   s = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11;
            default: s = '0;
        endcase
        return word_t'(s);
    endfunction

    // Register read as seen by decode with write-through
    function automatic word_t model_read(input reg_addr_t a);
        if (a == 5'd0) begin
            return '0;
        end
        if (wb_en && wb_addr == a) begin
            return wb_data;
        end
        return shadow[a];
    endfunction

    function automatic logic all_covered();
        foreach (cover_cnt[k]) begin
            if (cover_cnt[k] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string what);
        $display("MISMATCH at time %0t: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // Reference model updating on the same edge as ID/EX
    always @(posedge clk) begin
        if (rst) begin
            exp_instr   <= '0;
            exp_valid   <= 1'b0;
            exp_illegal <= 1'b0;
            exp_imm_sel <= IMM_NONE;
            exp_imm     <= '0;
        end else if (!stall) begin
            exp_instr   <= instruction;
            exp_valid   <= instr_valid;
            exp_illegal <= instr_valid && !opcode_known(instruction[6:0]);
            exp_imm_sel <= expected_format(instruction[6:0]);
            exp_imm     <= expected_immediate(instruction, expected_format(instruction[6:0]));
        end
        // Operand slots have no reset
        if (!stall) begin
            exp_rs1 <= model_read(instruction[19:15]);
            exp_rs2 <= model_read(instruction[24:20]);
        end
        if (wb_en && wb_addr != 5'd0) begin
            shadow[wb_addr] <= wb_data;
        end
        // Cover counting
        if (!rst) begin
            if (!stall && instr_valid) begin
                cover_cnt[expected_format(instruction[6:0])]++;
                if (instruction[6:0] == OPC_JALR) cover_cnt[COV_JALR]++;
                if (!opcode_known(instruction[6:0])) cover_cnt[COV_ILL_V]++;
            end
            if (!stall && !instr_valid && !opcode_known(instruction[6:0])) begin
                cover_cnt[COV_ILL_INV]++;
            end
            if (!stall && wb_en && wb_addr != 5'd0 &&
                (wb_addr == instruction[19:15] || wb_addr == instruction[24:20])) begin
                cover_cnt[COV_WT]++;
            end
            if (!stall && x0_written &&
                (instruction[19:15] == 5'd0 || instruction[24:20] == 5'd0)) begin
                cover_cnt[COV_X0]++;
            end
            if (stall && wb_en) cover_cnt[COV_STALL]++;
            if (wb_en && wb_addr == 5'd0) x0_written = 1'b1;
        end
    end

    // Control half against the model
    a_instr: assert property (@(posedge clk) disable iff (rst)
        instr_exe == exp_instr && valid_exe == exp_valid)
        else report_mismatch($sformatf("instr_exe %h valid_exe %b, expected %h %b",
            $sampled(instr_exe), $sampled(valid_exe), $sampled(exp_instr), $sampled(exp_valid)));

    a_format: assert property (@(posedge clk) disable iff (rst)
        imm_sel_exe == exp_imm_sel && illegal_exe == exp_illegal)
        else report_mismatch($sformatf("imm_sel_exe %0d illegal_exe %b, expected %0d %b",
            $sampled(imm_sel_exe), $sampled(illegal_exe),
            $sampled(exp_imm_sel), $sampled(exp_illegal)));

    // Immediate against the format rules
    a_imm: assert property (@(posedge clk) disable iff (rst) imm_exe == exp_imm)
        else report_mismatch($sformatf("imm_exe %h, expected %h",
            $sampled(imm_exe), $sampled(exp_imm)));

    // Operands including write-through and x0
    a_operands: assert property (@(posedge clk) disable iff (rst)
        rs1_data_exe == exp_rs1 && rs2_data_exe == exp_rs2)
        else report_mismatch($sformatf("rs1/rs2 %h %h, expected %h %h",
            $sampled(rs1_data_exe), $sampled(rs2_data_exe),
            $sampled(exp_rs1), $sampled(exp_rs2)));

    // ID/EX frozen under stall
    a_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(instr_exe) && $stable(valid_exe) && $stable(illegal_exe) &&
                  $stable(imm_sel_exe) && $stable(imm_exe) &&
                  $stable(rs1_data_exe) && $stable(rs2_data_exe))
        else report_mismatch("ID/EX output changed while stalled");

    // Reset values
    a_reset: assert property (@(posedge clk)
        rst |=> !valid_exe && !illegal_exe && instr_exe == '0 &&
                imm_sel_exe == IMM_NONE && imm_exe == '0)
        else report_mismatch("ID/EX not cleared by reset");

    task automatic drive_random();
        int      pick;
        opcode_t opc;
        word_t   word;
        pick = $unsigned($random(seed)) % 13;
        if (pick < 11) begin
            opc = legal_opc[pick];
        end else begin
            opc = bad_opc[$unsigned($random(seed)) % 4];
        end
        word        = $random(seed);
        word[6:0]   = opc;
        instruction = word;
        instr_valid = ($unsigned($random(seed)) % 4) != 0;
        stall       = ($unsigned($random(seed)) % 5) == 0;
        wb_en       = ($unsigned($random(seed)) % 2) == 0;
        // Steer some write-backs onto rs1 to hit write-through
        if (($unsigned($random(seed)) % 4) == 0) begin
            wb_addr = word[19:15];
        end else begin
            wb_addr = reg_addr_t'($random(seed));
        end
        wb_data = $random(seed);
    endtask

    initial begin
        reg_addr_t r5;
        foreach (cover_cnt[k]) cover_cnt[k] = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Fill every register so later reads are known
        for (int r = 1; r < NUM_REGS; r++) begin
            r5      = r[4:0];
            wb_en   = 1'b1;
            wb_addr = r5;
            wb_data = {r5, 3'b101, r5, 3'b010, r5, r5, r5, 1'b1};
            @(negedge clk);
        end
        wb_en  = 1'b0;
        cycles = 0;
        // Random phase bounded by RUN_LIMIT
        while (!(all_covered() && cycles >= MIN_CYCLES) && cycles < RUN_LIMIT) begin
            drive_random();
            @(negedge clk);
            cycles++;
        end
        stall       = 1'b0;
        wb_en       = 1'b0;
        instr_valid = 1'b0;
        // Let the last load reach the checks
        repeat (2) @(negedge clk);
        if (all_covered()) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Timeout: not every behavior was exercised in %0d cycles", RUN_LIMIT);
            $display("Verification failed");
            $fatal(1, "run ended before every behavior was exercised");
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // From fetch
    input  wire rv_isa_pkg::word_t     instruction,
    input  wire logic                  instr_valid,

    // Back-pressure from execute
    input  wire logic                  stall,

    // Write-back port
    input  wire logic                  wb_en,
    input  wire rv_isa_pkg::reg_addr_t wb_addr,
    input  wire rv_isa_pkg::word_t     wb_data,

    // ID/EX toward execute
    output rv_isa_pkg::word_t          instr_exe,
    output logic                       valid_exe,
    output logic                       illegal_exe,
    output rv_ctrl_pkg::imm_sel_t      imm_sel_exe,
    output rv_isa_pkg::word_t          imm_exe,
    output rv_isa_pkg::word_t          rs1_data_exe,
    output rv_isa_pkg::word_t          rs2_data_exe
);

    import rv_ctrl_pkg::*;

    // Format code, decoder to generator
    imm_sel_t imm_sel;

    // Shared ID/EX enable
    logic ex_load;

    // Opcode decode and control half of ID/EX
    decode_ctl i_decode_ctl (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .stall       (stall),
        .imm_sel     (imm_sel),
        .ex_load     (ex_load),
        .instr_exe   (instr_exe),
        .valid_exe   (valid_exe),
        .illegal_exe (illegal_exe),
        .imm_sel_exe (imm_sel_exe)
    );

    // Immediate slot
    imm_gen i_imm_gen (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .imm_sel     (imm_sel),
        .ex_load     (ex_load),
        .imm_exe     (imm_exe)
    );

    // Operand slots
    // Sources taken from the same instruction word
    reg_file i_reg_file (
        .clk          (clk),
        .rst          (rst),
        .instruction  (instruction),
        .ex_load      (ex_load),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .rs1_data_exe (rs1_data_exe),
        .rs2_data_exe (rs2_data_exe)
    );

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rv_isa_pkg::word_t     instruction,
    input  wire logic                  ex_load,
    input  wire logic                  wb_en,
    input  wire rv_isa_pkg::reg_addr_t wb_addr,
    input  wire rv_isa_pkg::word_t     wb_data,
    output rv_isa_pkg::word_t          rs1_data_exe,
    output rv_isa_pkg::word_t          rs2_data_exe
);

    import rv_isa_pkg::*;

    // Architectural registers, entry 0 never written
    word_t regs [NUM_REGS];

    // Source indices straight from the instruction
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    // Write-back that actually changes state
    logic wb_write;

    // x0 reads zero, a same-cycle write bypasses the array
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_write && (wb_addr == addr)) begin
            data = wb_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_addr = instruction[RS1_LSB +: REG_ADDR_W];
    assign rs2_addr = instruction[RS2_LSB +: REG_ADDR_W];

    // Writes to x0 dropped here
    assign wb_write = wb_en && (wb_addr != '0);

    // Write-back ignores stall
    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Operand slots of ID/EX
    always_ff @(posedge clk) begin
        if (ex_load) begin
            rs1_data_exe <= read_port(rs1_addr);
            rs2_data_exe <= read_port(rs2_addr);
        end
    end

    // x0 source gives a zero operand in execute
    a_rs1_x0: assert property (@(posedge clk) disable iff (rst)
        ex_load && (rs1_addr == '0) |=> rs1_data_exe == '0);

    a_rs2_x0: assert property (@(posedge clk) disable iff (rst)
        ex_load && (rs2_addr == '0) |=> rs2_data_exe == '0);

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module imm_gen (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rv_isa_pkg::word_t     instruction,
    input  wire rv_ctrl_pkg::imm_sel_t imm_sel,
    input  wire logic                  ex_load,
    output rv_isa_pkg::word_t          imm_exe
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Immediate for the instruction now in decode
    word_t imm;

    // Sign bit of every signed format
    logic sign;

    assign sign = instruction[XLEN-1];

    always_comb begin
        case (imm_sel)
            // imm[11:0] from the rs2 field upward
            IMM_I: begin
                imm = {{20{sign}}, instruction[31:RS2_LSB]};
            end
            // Upper seven bits above rs2, low five in the rd slot
            IMM_S: begin
                imm = {{20{sign}}, instruction[31:25], instruction[RD_LSB +: 5]};
            end
            // imm[11] sits at bit 7, imm[0] is implied zero
            IMM_B: begin
                imm = {{19{sign}}, sign, instruction[RD_LSB],
                       instruction[30:25], instruction[RD_LSB+4:RD_LSB+1], 1'b0};
            end
            // Upper twenty bits, low part zero
            IMM_U: begin
                imm = {instruction[31:12], 12'h000};
            end
            // imm[19:12] in place, imm[11] at bit 20
            IMM_J: begin
                imm = {{11{sign}}, sign, instruction[19:12],
                       instruction[RS2_LSB], instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // Immediate slot of ID/EX
    always_ff @(posedge clk) begin
        if (rst) begin
            imm_exe <= '0;
        end else if (ex_load) begin
            imm_exe <= imm;
        end
    end

    // Upper immediates land with a clear low part
    a_u_low_zero: assert property (@(posedge clk) disable iff (rst)
        ex_load && (imm_sel == IMM_U) |=> imm_exe[11:0] == 12'h000);

    // Branch and jump offsets stay halfword aligned
    a_bj_even: assert property (@(posedge clk) disable iff (rst)
        ex_load && (imm_sel == IMM_B || imm_sel == IMM_J) |=> !imm_exe[0]);

endmodule

`default_nettype wire

/* hdl/decode_ctl.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_ctl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rv_isa_pkg::word_t     instruction,
    input  wire logic                  instr_valid,
    input  wire logic                  stall,
    output rv_ctrl_pkg::imm_sel_t      imm_sel,
    output logic                       ex_load,
    output rv_isa_pkg::word_t          instr_exe,
    output logic                       valid_exe,
    output logic                       illegal_exe,
    output rv_ctrl_pkg::imm_sel_t      imm_sel_exe
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Major opcode of the instruction in decode
    opcode_t opcode;

    // Opcode belongs to the RV32I base set
    logic known_opc;

    // Illegal only counts for a real instruction
    logic illegal;

    assign opcode = instruction[OPCODE_W-1:0];

    // Opcode to immediate format
    always_comb begin
        imm_sel   = IMM_NONE;
        known_opc = 1'b1;
        case (opcode)
            // LUI and AUIPC take the upper immediate
            OPC_LUI,
            OPC_AUIPC: begin
                imm_sel = IMM_U;
            end
            // JAL
            OPC_JAL: begin
                imm_sel = IMM_J;
            end
            // JALR is I format, not J
            OPC_JALR: begin
                imm_sel = IMM_I;
            end
            // BEQ, BNE, BLT, BGE, BLTU, BGEU
            OPC_BRANCH: begin
                imm_sel = IMM_B;
            end
            // LB, LH, LW, LBU, LHU
            OPC_LOAD: begin
                imm_sel = IMM_I;
            end
            // SB, SH, SW
            OPC_STORE: begin
                imm_sel = IMM_S;
            end
            // ADDI through SRAI, shifts use the low immediate bits
            OPC_OP_IMM: begin
                imm_sel = IMM_I;
            end
            // Register-register ops
            OPC_OP: begin
                imm_sel = IMM_NONE;
            end
            // FENCE treated as a no-immediate op
            OPC_FENCE: begin
                imm_sel = IMM_NONE;
            end
            // ECALL, EBREAK, CSR access
            OPC_SYSTEM: begin
                imm_sel = IMM_NONE;
            end
            // Outside the base set
            default: begin
                imm_sel   = IMM_NONE;
                known_opc = 1'b0;
            end
        endcase
    end

    // Bubbles never raise illegal
    assign illegal = instr_valid && !known_opc;

    // ID/EX advances whenever execute accepts
    assign ex_load = !stall;

    // Control half of ID/EX
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_exe   <= '0;
            valid_exe   <= 1'b0;
            illegal_exe <= 1'b0;
            imm_sel_exe <= IMM_NONE;
        end else if (ex_load) begin
            instr_exe   <= instruction;
            valid_exe   <= instr_valid;
            illegal_exe <= illegal;
            imm_sel_exe <= imm_sel;
        end
    end

    // Format code stays in the defined range
    a_imm_sel_range: assert property (@(posedge clk) imm_sel <= IMM_J);

    // Reset leaves a bubble in execute
    a_valid_after_rst: assert property (@(posedge clk) rst |=> !valid_exe);

endmodule

`default_nettype wire

/* hdl/rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

    // Width of the immediate format code
    localparam int IMM_SEL_W = 3;

    // Immediate format selector, decoder to generator
    typedef logic [IMM_SEL_W-1:0] imm_sel_t;

    // No immediate operand
    // R-type, FENCE, SYSTEM and anything unknown
    localparam imm_sel_t IMM_NONE = 3'd0;

    // I-type
    // JALR, loads, OP-IMM
    localparam imm_sel_t IMM_I    = 3'd1;

    // S-type, stores
    localparam imm_sel_t IMM_S    = 3'd2;

    // B-type, conditional branches
    localparam imm_sel_t IMM_B    = 3'd3;

    // U-type
    // LUI and AUIPC
    localparam imm_sel_t IMM_U    = 3'd4;

    // J-type, JAL only
    localparam imm_sel_t IMM_J    = 3'd5;

    // Codes 6 and 7 are never produced

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Datapath width of RV32I
    localparam int XLEN = 32;

    // Register index width, five bits for x0..x31
    localparam int REG_ADDR_W = 5;

    // Architectural register count
    localparam int NUM_REGS = 32;

    // Major opcode sits in the low bits of every instruction
    localparam int OPCODE_W = 7;

    // Low bit of each register field
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // One data or instruction word
    typedef logic [XLEN-1:0] word_t;

    // Register file index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcode field
    typedef logic [OPCODE_W-1:0] opcode_t;

    // Upper immediate group
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // Jumps
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // Conditional branches, BEQ through BGEU
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Loads and stores
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // Register-immediate and register-register ALU ops
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Memory ordering
    localparam opcode_t OPC_FENCE  = 7'b0001111;

    // ECALL, EBREAK and CSR space
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
